/* div_cfg.svh */
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// Operand widths.
`define DIV_N_W 16
`define DIV_D_W 8

// Low quotient rows built from inexact cells.
`define DIV_APPROX_ROWS 6

// Statistics.
`define DIV_CNT_W 16

`endif

/* div_data_pkg.sv */
`include "div_cfg.svh"

package div_data_pkg;

  // Operands.
  typedef logic [`DIV_N_W-1:0] dividend_t;
  typedef logic [`DIV_D_W-1:0] divisor_t;

  // Results.
  typedef logic [`DIV_D_W-1:0] quotient_t;
  typedef logic [`DIV_D_W-1:0] remainder_t;

  // Accuracy statistics.
  typedef logic [`DIV_D_W-1:0] q_error_t;
  typedef logic [`DIV_CNT_W-1:0] sample_cnt_t;

endpackage

/* div_ctrl_pkg.sv */
package div_ctrl_pkg;

  // Which array drives the result.
  typedef enum logic {
    MODE_EXACT  = 1'b0,
    MODE_APPROX = 1'b1
  } div_mode_e;

  // Operand classification.
  typedef enum logic [1:0] {
    STATUS_OK       = 2'd0,
    STATUS_DIV_ZERO = 2'd1,
    STATUS_OVERFLOW = 2'd2
  } div_status_e;

endpackage

/* div_cells.sv */
`timescale 1ns/10ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Exact subtractor cell.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module div_exact_cell (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  output logic r_sub,
  output logic bout
);

  logic diff;

  assign diff  = x ^ y ^ bin;
  assign bout  = (~x & y) | (~(x ^ y) & bin);
  // Restore x when the row does not subtract.
  assign r_sub = qs ? diff : x;

endmodule

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Approximate subtractor cell.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module div_approx_cell (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  output logic r_sub,
  output logic bout
);

  logic diff;

  // Difference is low only for x=0, y=1 and bin=0.
  assign bout  = bin | ~y;
  assign diff  = x | ~y | bin;
  assign r_sub = qs ? diff : x;

endmodule

/* div_array.sv */
`timescale 1ns/10ps
`include "div_cfg.svh"

module div_array #(
  parameter int APPROX_ROWS = `DIV_APPROX_ROWS
) (
  input  div_data_pkg::dividend_t  dividend,
  input  div_data_pkg::divisor_t   divisor,
  output div_data_pkg::quotient_t  quotient,
  output div_data_pkg::remainder_t remainder
);

  localparam int NW = `DIV_N_W;
  localparam int DW = `DIV_D_W;

  // Partial remainder, restored remainder and borrow chain of each row.
  logic [DW-1:0] row_x [DW];
  logic [DW-1:0] row_r [DW];
  logic [DW-1:0] row_b [DW];
  // Bit shifted out above each row.
  logic [DW-1:0] row_msb;

  for (genvar i = 0; i < DW; i++) begin : g_row

    // Top row takes the dividend directly, the rest take the row above.
    if (i == DW - 1) begin : g_top
      assign row_x[i]   = dividend[NW-2:DW-1];
      assign row_msb[i] = dividend[NW-1];
    end else begin : g_inner
      assign row_x[i]   = {row_r[i+1][DW-2:0], dividend[i]};
      assign row_msb[i] = row_r[i+1][DW-1];
    end

    // Subtract fits, or the shifted-out bit makes it fit anyway.
    assign quotient[i] = row_msb[i] | ~row_b[i][DW-1];

    for (genvar j = 0; j < DW; j++) begin : g_col
      logic bin;

      if (j == 0) begin : g_lsb
        assign bin = 1'b0;
      end else begin : g_chain
        assign bin = row_b[i][j-1];
      end

      if (i < APPROX_ROWS) begin : g_approx
        div_approx_cell u_cell (
          .x     (row_x[i][j]),
          .y     (divisor[j]),
          .bin   (bin),
          .qs    (quotient[i]),
          .r_sub (row_r[i][j]),
          .bout  (row_b[i][j])
        );
      end else begin : g_exact
        div_exact_cell u_cell (
          .x     (row_x[i][j]),
          .y     (divisor[j]),
          .bin   (bin),
          .qs    (quotient[i]),
          .r_sub (row_r[i][j]),
          .bout  (row_b[i][j])
        );
      end
    end
  end

  assign remainder = row_r[0];

endmodule

/* div_decode.sv */
`timescale 1ns/10ps
`include "div_cfg.svh"

module div_decode (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  div_ctrl_pkg::div_mode_e    mode,
  input  div_data_pkg::dividend_t    dividend,
  input  div_data_pkg::divisor_t     divisor,
  output logic                       dec_valid,
  output div_ctrl_pkg::div_mode_e    dec_mode,
  output div_data_pkg::dividend_t    dec_dividend,
  output div_data_pkg::divisor_t     dec_divisor,
  output div_ctrl_pkg::div_status_e  dec_status
);

  import div_ctrl_pkg::*;
  import div_data_pkg::*;

  divisor_t    dividend_hi;
  div_status_e status_next;

  // Quotient only has DIV_D_W bits, so the upper byte must stay below the divisor.
  assign dividend_hi = dividend[`DIV_N_W-1 -: `DIV_D_W];

  always_comb begin
    if (divisor == '0) begin
      status_next = STATUS_DIV_ZERO;
    end else if (dividend_hi >= divisor) begin
      status_next = STATUS_OVERFLOW;
    end else begin
      status_next = STATUS_OK;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      dec_mode     <= mode;
      dec_dividend <= dividend;
      dec_divisor  <= divisor;
      dec_status   <= status_next;
    end
  end

endmodule

/* div_execute.sv */
`timescale 1ns/10ps
`include "div_cfg.svh"

module div_execute (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       dec_valid,
  input  div_ctrl_pkg::div_mode_e    dec_mode,
  input  div_data_pkg::dividend_t    dec_dividend,
  input  div_data_pkg::divisor_t     dec_divisor,
  input  div_ctrl_pkg::div_status_e  dec_status,
  output logic                       exe_valid,
  output div_ctrl_pkg::div_mode_e    exe_mode,
  output div_ctrl_pkg::div_status_e  exe_status,
  output div_data_pkg::quotient_t    q_exact,
  output div_data_pkg::remainder_t   r_exact,
  output div_data_pkg::quotient_t    q_approx,
  output div_data_pkg::remainder_t   r_approx
);

  import div_data_pkg::*;

  quotient_t  q_exact_comb;
  remainder_t r_exact_comb;
  quotient_t  q_approx_comb;
  remainder_t r_approx_comb;

  // Reference array without inexact rows.
  div_array #(.APPROX_ROWS(0)) u_exact_array (
    .dividend  (dec_dividend),
    .divisor   (dec_divisor),
    .quotient  (q_exact_comb),
    .remainder (r_exact_comb)
  );

  div_array #(.APPROX_ROWS(`DIV_APPROX_ROWS)) u_approx_array (
    .dividend  (dec_dividend),
    .divisor   (dec_divisor),
    .quotient  (q_approx_comb),
    .remainder (r_approx_comb)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      exe_valid <= 1'b0;
    end else begin
      exe_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      exe_mode   <= dec_mode;
      exe_status <= dec_status;
      q_exact    <= q_exact_comb;
      r_exact    <= r_exact_comb;
      q_approx   <= q_approx_comb;
      r_approx   <= r_approx_comb;
    end
  end

endmodule

/* div_result.sv */
`timescale 1ns/10ps

module div_result (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       exe_valid,
  input  div_ctrl_pkg::div_mode_e    exe_mode,
  input  div_ctrl_pkg::div_status_e  exe_status,
  input  div_data_pkg::quotient_t    q_exact,
  input  div_data_pkg::remainder_t   r_exact,
  input  div_data_pkg::quotient_t    q_approx,
  input  div_data_pkg::remainder_t   r_approx,
  input  logic                       clear_stats,
  output logic                       done,
  output div_data_pkg::quotient_t    quotient,
  output div_data_pkg::remainder_t   remainder,
  output div_data_pkg::q_error_t     q_error,
  output div_ctrl_pkg::div_status_e  status,
  output div_data_pkg::q_error_t     max_q_error,
  output div_data_pkg::sample_cnt_t  sample_count
);

  import div_ctrl_pkg::*;
  import div_data_pkg::*;

  quotient_t  q_sel;
  remainder_t r_sel;
  q_error_t   q_diff;
  logic       sample_ok;

  assign sample_ok = exe_valid && (exe_status == STATUS_OK);
  assign q_sel     = (exe_mode == MODE_APPROX) ? q_approx : q_exact;
  assign r_sel     = (exe_mode == MODE_APPROX) ? r_approx : r_exact;
  // Distance between the two quotients.
  assign q_diff    = (q_exact > q_approx) ? q_exact - q_approx : q_approx - q_exact;

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= exe_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (exe_valid) begin
      status <= exe_status;
      if (exe_status == STATUS_OK) begin
        quotient  <= q_sel;
        remainder <= r_sel;
        q_error   <= q_diff;
      end else begin
        quotient  <= '1;
        remainder <= '0;
        q_error   <= '0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Error statistics.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset || clear_stats) begin
      sample_count <= '0;
      max_q_error  <= '0;
    end else if (sample_ok) begin
      sample_count <= sample_count + 1'b1;
      if (q_diff > max_q_error) begin
        max_q_error <= q_diff;
      end
    end
  end

endmodule

/* approx_div_top.sv */
`timescale 1ns/10ps

module approx_div_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  div_ctrl_pkg::div_mode_e    mode,
  input  div_data_pkg::dividend_t    dividend,
  input  div_data_pkg::divisor_t     divisor,
  input  logic                       clear_stats,
  output logic                       done,
  output div_data_pkg::quotient_t    quotient,
  output div_data_pkg::remainder_t   remainder,
  output div_data_pkg::q_error_t     q_error,
  output div_ctrl_pkg::div_status_e  status,
  output div_data_pkg::q_error_t     max_q_error,
  output div_data_pkg::sample_cnt_t  sample_count
);

  import div_ctrl_pkg::*;
  import div_data_pkg::*;

  logic        dec_valid;
  div_mode_e   dec_mode;
  dividend_t   dec_dividend;
  divisor_t    dec_divisor;
  div_status_e dec_status;

  logic        exe_valid;
  div_mode_e   exe_mode;
  div_status_e exe_status;
  quotient_t   q_exact;
  remainder_t  r_exact;
  quotient_t   q_approx;
  remainder_t  r_approx;

  div_decode u_decode (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .mode         (mode),
    .dividend     (dividend),
    .divisor      (divisor),
    .dec_valid    (dec_valid),
    .dec_mode     (dec_mode),
    .dec_dividend (dec_dividend),
    .dec_divisor  (dec_divisor),
    .dec_status   (dec_status)
  );

  div_execute u_execute (
    .clk          (clk),
    .reset        (reset),
    .dec_valid    (dec_valid),
    .dec_mode     (dec_mode),
    .dec_dividend (dec_dividend),
    .dec_divisor  (dec_divisor),
    .dec_status   (dec_status),
    .exe_valid    (exe_valid),
    .exe_mode     (exe_mode),
    .exe_status   (exe_status),
    .q_exact      (q_exact),
    .r_exact      (r_exact),
    .q_approx     (q_approx),
    .r_approx     (r_approx)
  );

  div_result u_result (
    .clk          (clk),
    .reset        (reset),
    .exe_valid    (exe_valid),
    .exe_mode     (exe_mode),
    .exe_status   (exe_status),
    .q_exact      (q_exact),
    .r_exact      (r_exact),
    .q_approx     (q_approx),
    .r_approx     (r_approx),
    .clear_stats  (clear_stats),
    .done         (done),
    .quotient     (quotient),
    .remainder    (remainder),
    .q_error      (q_error),
    .status       (status),
    .max_q_error  (max_q_error),
    .sample_count (sample_count)
  );

endmodule

/* tb_approx_div.sv */
`timescale 1ns/10ps
`include "div_cfg.svh"

module tb_approx_div;

  import div_ctrl_pkg::*;
  import div_data_pkg::*;

  logic        clk;
  logic        reset;
  logic        start;
  logic        clear_stats;
  div_mode_e   mode;
  dividend_t   dividend;
  divisor_t    divisor;
  logic        done;
  quotient_t   quotient;
  remainder_t  remainder;
  q_error_t    q_error;
  div_status_e status;
  q_error_t    max_q_error;
  sample_cnt_t sample_count;

  integer seed;
  int     cycle = 0;

  // Expected results in issue order.
  quotient_t   exp_q[$];
  remainder_t  exp_r[$];
  q_error_t    exp_err[$];
  div_status_e exp_st[$];
  int          exp_cyc[$];

  // Statistics model.
  q_error_t    m_max;
  sample_cnt_t m_count;

  approx_div_top approx_div_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("Some tests failed");
      $fatal(1, "Mismatch");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bit-level array model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [15:0] approx_model(input dividend_t n, input divisor_t d);
    quotient_t  q;
    logic [7:0] r;
    logic [7:0] x;
    logic [7:0] diff;
    logic [8:0] sub;
    logic       msb;
    logic       b;
    q = '0;
    r = '0;
    for (int i = 7; i >= 0; i--) begin
      if (i == 7) begin
        x   = n[14:7];
        msb = n[15];
      end else begin
        x   = {r[6:0], n[i]};
        msb = r[7];
      end
      if (i < `DIV_APPROX_ROWS) begin
        b = 1'b0;
        for (int j = 0; j < 8; j++) begin
          diff[j] = x[j] | ~d[j] | b;
          b       = b | ~d[j];
        end
      end else begin
        // Exact row is a plain subtraction with the borrow on top.
        sub  = {1'b0, x} - {1'b0, d};
        diff = sub[7:0];
        b    = sub[8];
      end
      q[i] = msb | ~b;
      r    = q[i] ? diff : x;
    end
    return {q, r};
  endfunction

  task automatic issue_cmd(input div_mode_e m, input dividend_t n, input divisor_t d);
    logic [15:0] ap;
    quotient_t   qx;
    remainder_t  rx;
    div_status_e st;
    ap = approx_model(n, d);
    if (d == 0) begin
      st = STATUS_DIV_ZERO;
    end else if (n[15:8] >= d) begin
      st = STATUS_OVERFLOW;
    end else begin
      st = STATUS_OK;
    end
    if (st == STATUS_OK) begin
      qx = n / d;
      rx = n % d;
      exp_q.push_back((m == MODE_APPROX) ? ap[15:8] : qx);
      exp_r.push_back((m == MODE_APPROX) ? ap[7:0] : rx);
      exp_err.push_back((qx > ap[15:8]) ? qx - ap[15:8] : ap[15:8] - qx);
    end else begin
      exp_q.push_back(8'hff);
      exp_r.push_back(8'h00);
      exp_err.push_back(8'h00);
    end
    exp_st.push_back(st);
    // Done shows up three clocks after the cycle that drives start.
    exp_cyc.push_back(cycle + 3);
    start    = 1'b1;
    mode     = m;
    dividend = n;
    divisor  = d;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  // Operands that cannot overflow the quotient.
  task automatic pick_ok(output dividend_t n, output divisor_t d);
    logic [31:0] w;
    divisor_t    hi;
    w = $random(seed);
    d = w[7:0];
    if (d == 0) begin
      d = 8'd1;
    end
    hi = w[31:16] % d;
    n  = {hi, w[15:8]};
  endtask

  task automatic wait_drain();
    int count;
    count = 0;
    while (exp_cyc.size() != 0) begin
      if (count == 20) begin
        $display("Timeout: done never came for %0d pending commands", exp_cyc.size());
        $display("Some tests failed");
        $fatal(1, "Timeout");
      end
      @(posedge clk);
      #1;
      count++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Result monitor.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk) begin : monitor
    div_status_e st;
    q_error_t    err;
    if (!reset && done) begin
      if (exp_cyc.size() == 0) begin
        $display("Error: done pulsed at %0t ns with no command pending", $time);
        $display("Some tests failed");
        $fatal(1, "Unexpected done");
      end else begin
        st  = exp_st.pop_front();
        err = exp_err.pop_front();
        check(cycle, exp_cyc.pop_front(), "done cycle");
        check(status, st, "status");
        check(quotient, exp_q.pop_front(), "quotient");
        check(remainder, exp_r.pop_front(), "remainder");
        check(q_error, err, "q_error");
        if (st == STATUS_OK) begin
          m_count = m_count + 1'b1;
          if (err > m_max) begin
            m_max = err;
          end
        end
        check(sample_count, m_count, "sample_count");
        check(max_q_error, m_max, "max_q_error");
      end
    end
  end

  initial begin
    dividend_t   n;
    divisor_t    d;
    logic [31:0] w;
    seed        = 32'h8116f046;
    reset       = 1'b1;
    start       = 1'b0;
    clear_stats = 1'b0;
    mode        = MODE_EXACT;
    dividend    = '0;
    divisor     = '0;
    m_max       = '0;
    m_count     = '0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check(done, 1'b0, "done after reset");
    check(sample_count, 0, "sample_count after reset");
    check(max_q_error, 0, "max_q_error after reset");
    @(posedge clk);
    #1;

    // Exact mode with one command at a time.
    repeat (30) begin
      pick_ok(n, d);
      issue_cmd(MODE_EXACT, n, d);
      wait_drain();
    end

    // Approximate mode issued back to back.
    repeat (60) begin
      pick_ok(n, d);
      issue_cmd(MODE_APPROX, n, d);
    end
    wait_drain();

    // Zero divisor and overflow corners.
    issue_cmd(MODE_EXACT, 16'h1234, 8'h00);
    issue_cmd(MODE_APPROX, 16'hffff, 8'h00);
    issue_cmd(MODE_EXACT, 16'h1000, 8'h10);
    issue_cmd(MODE_APPROX, 16'hff00, 8'hff);
    issue_cmd(MODE_EXACT, 16'h0fff, 8'h10);
    issue_cmd(MODE_APPROX, 16'h0100, 8'h01);
    wait_drain();

    // Mixed modes and unconstrained operands issued back to back.
    repeat (40) begin
      w = $random(seed);
      issue_cmd(div_mode_e'(w[24]), w[15:0], w[23:16]);
    end
    wait_drain();

    clear_stats = 1'b1;
    @(posedge clk);
    #1;
    clear_stats = 1'b0;
    m_count     = '0;
    m_max       = '0;
    @(negedge clk);
    check(sample_count, 0, "sample_count after clear");
    check(max_q_error, 0, "max_q_error after clear");
    @(posedge clk);
    #1;

    repeat (20) begin
      pick_ok(n, d);
      issue_cmd(MODE_APPROX, n, d);
    end
    wait_drain();
    check(sample_count, m_count, "final sample_count");

    $display("All tests passed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
div_data_pkg.sv
div_ctrl_pkg.sv
div_cells.sv
div_array.sv
div_decode.sv
div_execute.sv
div_result.sv
approx_div_top.sv
tb_approx_div.sv

/* Bender.yml */
package:
  name: approx_div

export_include_dirs:
  - .

sources:
  - files:
      - div_data_pkg.sv
      - div_ctrl_pkg.sv
      - div_cells.sv
      - div_array.sv
      - div_decode.sv
      - div_execute.sv
      - div_result.sv
      - approx_div_top.sv
  - target: test
    files:
      - tb_approx_div.sv
